//--- nvram_pkg.sv
`default_nettype none

package nvram_pkg;

   // Slots: ROM save, extension A, extension B, CMOS
   localparam int slot_count = 4;
   localparam int slot_w     = 2;

   localparam int ram_addr_w = 27;   // RAM byte address
   localparam int lba_w      = 32;   // SD block address

   // Region size in 1 KiB units
   localparam int size_w         = 16;
   localparam int blocks_per_kib = 2;

   localparam int block_bytes_log2 = 9;   // 512-byte SD blocks
   localparam int block_count_w    = 21;

   localparam int img_size_w = 64;   // Image size in bytes

   typedef enum logic {
      MOVE_IDLE,
      MOVE_TRANSFER
   } mover_state_t;

endpackage

`default_nettype wire

//--- nvram_image_status.sv
`timescale 1ns/100ps
`default_nettype none

module nvram_image_status (
   input  wire                                clk,
   input  wire                                rst_n,
   input  wire  [nvram_pkg::slot_count-1:0]   img_mounted,
   input  wire                                img_readonly,
   input  wire  [nvram_pkg::img_size_w-1:0]   img_size,
   input  wire                                size_commit,
   input  wire  [nvram_pkg::slot_w-1:0]       slot,
   input  wire  [nvram_pkg::size_w-1:0]       sram_size [nvram_pkg::slot_count],
   output logic [nvram_pkg::slot_count-1:0]   writable,
   output logic [nvram_pkg::img_size_w-1:0]   image_size [nvram_pkg::slot_count]
);

   // Bytes per size unit
   localparam int unit_bytes = nvram_pkg::blocks_per_kib << nvram_pkg::block_bytes_log2;

   logic [nvram_pkg::img_size_w-1:0] commit_size;

   // Region size in bytes for the active slot
   assign commit_size = nvram_pkg::img_size_w'(sram_size[slot])
                        * nvram_pkg::img_size_w'(unit_bytes);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         writable   <= '0;
         image_size <= '{default: '0};
      end else begin
         for (int s = 0; s < nvram_pkg::slot_count; s++) begin
            if (img_mounted[s]) begin
               writable[s]   <= ~img_readonly;   // Read-only counts as not writable
               image_size[s] <= img_size;
            end
         end
         // Image now holds the whole region
         if (size_commit)
            image_size[slot] <= commit_size;
      end
   end

endmodule

`default_nettype wire

//--- nvram_request_scheduler.sv
`timescale 1ns/100ps
`default_nettype none

module nvram_request_scheduler (
   input  wire                                clk,
   input  wire                                rst_n,
   input  wire                                load_req,
   input  wire                                save_req,
   input  wire                                op_done,
   output logic [nvram_pkg::slot_w-1:0]       slot,
   output logic                               op_load,
   output logic                               op_save,
   output logic                               busy
);

   logic                              last_load_req;
   logic                              last_save_req;
   logic                              load_edge;
   logic                              save_edge;
   logic [nvram_pkg::slot_count-1:0]  pend_load;
   logic [nvram_pkg::slot_count-1:0]  pend_save;
   logic                              idle;

   assign load_edge = load_req & ~last_load_req;
   assign save_edge = save_req & ~last_save_req;
   assign idle      = ~op_load & ~op_save;

   assign busy = (|pend_load) | (|pend_save) | op_load | op_save;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         last_load_req <= 1'b0;
         last_save_req <= 1'b0;
         pend_load     <= '0;
         pend_save     <= '0;
         slot          <= '0;
         op_load       <= 1'b0;
         op_save       <= 1'b0;
      end else begin
         last_load_req <= load_req;
         last_save_req <= save_req;

         if (op_done) begin
            op_load <= 1'b0;
            op_save <= 1'b0;
            if (op_save)
               pend_save[slot] <= 1'b0;
            if (op_load)
               pend_load[slot] <= 1'b0;
         end else if (idle) begin
            // Save wins over load on the same slot
            if (pend_save[slot])
               op_save <= 1'b1;
            else if (pend_load[slot])
               op_load <= 1'b1;
            else
               slot <= slot + nvram_pkg::slot_w'(1);   // Wraps 3 to 0
         end

         // A new request re-queues every slot, even mid-transfer
         if (load_edge)
            pend_load <= '1;
         if (save_edge)
            pend_save <= '1;
      end
   end

endmodule

`default_nettype wire

//--- nvram_block_mover.sv
`timescale 1ns/100ps
`default_nettype none

module nvram_block_mover (
   input  wire                                      clk,
   input  wire                                      rst_n,
   input  wire  [nvram_pkg::slot_w-1:0]             slot,
   input  wire                                      op_load,
   input  wire                                      op_save,
   input  wire  [nvram_pkg::ram_addr_w-1:0]         sram_base [nvram_pkg::slot_count],
   input  wire  [nvram_pkg::size_w-1:0]             sram_size [nvram_pkg::slot_count],
   input  wire  [nvram_pkg::slot_count-1:0]         writable,
   input  wire  [nvram_pkg::img_size_w-1:0]         image_size [nvram_pkg::slot_count],
   input  wire  [nvram_pkg::slot_count-1:0]         sd_ack,
   input  wire  [nvram_pkg::block_bytes_log2-1:0]   sd_buff_addr,
   output logic [nvram_pkg::lba_w-1:0]              sd_lba [nvram_pkg::slot_count],
   output logic [nvram_pkg::slot_count-1:0]         sd_rd,
   output logic [nvram_pkg::slot_count-1:0]         sd_wr,
   output logic [nvram_pkg::ram_addr_w-1:0]         ram_addr,
   output logic                                     ram_we,
   output logic                                     op_done,
   output logic                                     size_commit
);

   nvram_pkg::mover_state_t state;

   logic [nvram_pkg::block_count_w-1:0] block_count;
   logic [nvram_pkg::block_count_w-1:0] total_blocks;
   logic                                last_ack;
   logic                                ack_fall;
   logic                                start;
   logic                                eligible;
   logic                                last_block;

   assign start = (op_load | op_save) & ~op_done;

   // Load also needs a non-empty image
   assign eligible = (sram_size[slot] != '0) && writable[slot]
                     && (op_save || (image_size[slot] != '0));

   assign total_blocks = nvram_pkg::block_count_w'(sram_size[slot])
                         * nvram_pkg::block_count_w'(nvram_pkg::blocks_per_kib);

   assign ack_fall   = ~sd_ack[slot] & last_ack;
   assign last_block = sd_lba[slot][nvram_pkg::block_count_w-1:0]
                       >= (block_count - nvram_pkg::block_count_w'(1));

   // Byte address of the current buffer position
   assign ram_addr = sram_base[slot]
                     + nvram_pkg::ram_addr_w'({sd_lba[slot], sd_buff_addr});
   assign ram_we   = sd_rd[slot] & sd_ack[slot];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state       <= nvram_pkg::MOVE_IDLE;
         sd_lba      <= '{default: '0};
         sd_rd       <= '0;
         sd_wr       <= '0;
         block_count <= '0;
         last_ack    <= 1'b0;
         op_done     <= 1'b0;
         size_commit <= 1'b0;
      end else begin
         op_done     <= 1'b0;
         size_commit <= 1'b0;
         last_ack    <= sd_ack[slot];
         case (state)
            nvram_pkg::MOVE_IDLE: begin
               if (start) begin
                  if (eligible) begin
                     sd_lba[slot] <= '0;
                     block_count  <= total_blocks;
                     sd_wr[slot]  <= op_save;
                     sd_rd[slot]  <= op_load;
                     state        <= nvram_pkg::MOVE_TRANSFER;
                  end else begin
                     op_done <= 1'b1;   // Skipped slot
                  end
               end
            end
            nvram_pkg::MOVE_TRANSFER: begin
               if (ack_fall) begin
                  if (!last_block) begin
                     sd_lba[slot] <= sd_lba[slot] + nvram_pkg::lba_w'(1);
                  end else begin
                     sd_wr[slot] <= 1'b0;
                     sd_rd[slot] <= 1'b0;
                     op_done     <= 1'b1;
                     size_commit <= sd_wr[slot];   // Only a save changes the image size
                     state       <= nvram_pkg::MOVE_IDLE;
                  end
               end
            end
         endcase
      end
   end

endmodule

`default_nettype wire

//--- nvram_backup.sv
`timescale 1ns/100ps
`default_nettype none

module nvram_backup (
   input  wire                                      clk,
   input  wire                                      rst_n,
   input  wire  [nvram_pkg::ram_addr_w-1:0]         sram_base [nvram_pkg::slot_count],
   input  wire  [nvram_pkg::size_w-1:0]             sram_size [nvram_pkg::slot_count],
   input  wire                                      load_req,
   input  wire                                      save_req,
   input  wire  [nvram_pkg::slot_count-1:0]         img_mounted,
   input  wire                                      img_readonly,
   input  wire  [nvram_pkg::img_size_w-1:0]         img_size,
   output logic [nvram_pkg::lba_w-1:0]              sd_lba [nvram_pkg::slot_count],
   output logic [nvram_pkg::slot_count-1:0]         sd_rd,
   output logic [nvram_pkg::slot_count-1:0]         sd_wr,
   input  wire  [nvram_pkg::slot_count-1:0]         sd_ack,
   input  wire  [nvram_pkg::block_bytes_log2-1:0]   sd_buff_addr,
   output logic [7:0]                               sd_buff_din [nvram_pkg::slot_count],
   output logic [nvram_pkg::ram_addr_w-1:0]         ram_addr,
   output logic                                     ram_we,
   input  wire  [7:0]                               ram_dout,
   output logic                                     busy
);

   logic [nvram_pkg::slot_w-1:0]      slot;
   logic                              op_load;
   logic                              op_save;
   logic                              op_done;
   logic                              size_commit;
   logic [nvram_pkg::slot_count-1:0]  writable;
   logic [nvram_pkg::img_size_w-1:0]  image_size [nvram_pkg::slot_count];

   // Save data comes straight from RAM for every slot
   for (genvar s = 0; s < nvram_pkg::slot_count; s++) begin : g_buff_din
      assign sd_buff_din[s] = ram_dout;
   end

   nvram_image_status image_status_i (
      .clk          (clk),
      .rst_n        (rst_n),
      .img_mounted  (img_mounted),
      .img_readonly (img_readonly),
      .img_size     (img_size),
      .size_commit  (size_commit),
      .slot         (slot),
      .sram_size    (sram_size),
      .writable     (writable),
      .image_size   (image_size)
   );

   nvram_request_scheduler request_scheduler_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .load_req (load_req),
      .save_req (save_req),
      .op_done  (op_done),
      .slot     (slot),
      .op_load  (op_load),
      .op_save  (op_save),
      .busy     (busy)
   );

   nvram_block_mover block_mover_i (
      .clk          (clk),
      .rst_n        (rst_n),
      .slot         (slot),
      .op_load      (op_load),
      .op_save      (op_save),
      .sram_base    (sram_base),
      .sram_size    (sram_size),
      .writable     (writable),
      .image_size   (image_size),
      .sd_ack       (sd_ack),
      .sd_buff_addr (sd_buff_addr),
      .sd_lba       (sd_lba),
      .sd_rd        (sd_rd),
      .sd_wr        (sd_wr),
      .ram_addr     (ram_addr),
      .ram_we       (ram_we),
      .op_done      (op_done),
      .size_commit  (size_commit)
   );

endmodule

`default_nettype wire

//--- nvram_backup_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module nvram_backup_assertions (
   input wire                                clk,
   input wire                                rst_n,
   input wire [nvram_pkg::slot_count-1:0]    sd_rd,
   input wire [nvram_pkg::slot_count-1:0]    sd_wr,
   input wire [nvram_pkg::slot_count-1:0]    sd_ack,
   input wire [nvram_pkg::lba_w-1:0]         sd_lba [nvram_pkg::slot_count],
   input wire                                ram_we
);

   rd_wr_exclusive: assert property (@(posedge clk) disable iff (!rst_n) (sd_rd & sd_wr) == '0)
      else $error("sd_rd and sd_wr high together");

   // One slot on the SD host at a time
   single_strobe: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(sd_rd | sd_wr))
      else $error("more than one slot strobe active");

   // RAM is written exactly while an sd_rd slot is acked
   we_follows_rd: assert property (@(posedge clk) disable iff (!rst_n)
                                   ram_we == ((sd_rd & sd_ack) != '0))
      else $error("ram_we does not follow an acked sd_rd");

   for (genvar s = 0; s < nvram_pkg::slot_count; s++) begin : g_lba
      lba_stable: assert property (@(posedge clk) disable iff (!rst_n)
                                   sd_ack[s] && $past(sd_ack[s]) |-> $stable(sd_lba[s]))
         else $error("sd_lba of slot %0d changed while sd_ack was high", s);
   end

endmodule

bind nvram_backup nvram_backup_assertions nvram_backup_assertions_i (
   .clk    (clk),
   .rst_n  (rst_n),
   .sd_rd  (sd_rd),
   .sd_wr  (sd_wr),
   .sd_ack (sd_ack),
   .sd_lba (sd_lba),
   .ram_we (ram_we)
);

`default_nettype wire

//--- tb_nvram_backup.sv
`timescale 1ns/100ps
`default_nettype none

module tb_nvram_backup;

   localparam int region_bytes = 4096;
   localparam int mem_bytes    = 4 * region_bytes;
   localparam int row_count    = 8;

   typedef struct packed {
      logic [3:0]      mount;
      logic            ro;
      logic [3:0]      img_kib;   // Image size sent with the mount
      logic [3:0][2:0] kib;       // Region sizes, slot 3 first
      logic            save;
      logic            hold;      // save_req stays high past the round
      logic [3:0]      served;
   } row_t;

   localparam row_t rows [row_count] = '{
      '{4'b0000, 1'b0, 4'd0, {3'd1, 3'd1, 3'd1, 3'd1}, 1'b1, 1'b0, 4'b0000},  // Nothing mounted
      '{4'b1111, 1'b0, 4'd0, {3'd1, 3'd0, 3'd2, 3'd1}, 1'b1, 1'b0, 4'b1011},
      '{4'b0000, 1'b0, 4'd0, {3'd1, 3'd1, 3'd2, 3'd1}, 1'b0, 1'b0, 4'b1011},  // Slot 2 image empty
      '{4'b0000, 1'b0, 4'd0, {3'd0, 3'd2, 3'd0, 3'd0}, 1'b1, 1'b0, 4'b0100},
      '{4'b0000, 1'b0, 4'd0, {3'd0, 3'd2, 3'd0, 3'd0}, 1'b0, 1'b0, 4'b0100},
      '{4'b0011, 1'b1, 4'd4, {3'd2, 3'd2, 3'd2, 3'd2}, 1'b1, 1'b0, 4'b1100},  // Slots 0 and 1 read-only
      '{4'b1000, 1'b0, 4'd3, {3'd3, 3'd2, 3'd1, 3'd1}, 1'b0, 1'b0, 4'b1100},
      '{4'b0000, 1'b0, 4'd0, {3'd2, 3'd1, 3'd0, 3'd2}, 1'b1, 1'b1, 4'b1100}
   };

   logic                                    clk;
   logic                                    rst_n;
   logic [nvram_pkg::ram_addr_w-1:0]        sram_base [4];
   logic [nvram_pkg::size_w-1:0]            sram_size [4];
   logic                                    load_req;
   logic                                    save_req;
   logic [3:0]                              img_mounted;
   logic                                    img_readonly;
   logic [nvram_pkg::img_size_w-1:0]        img_size;
   logic [nvram_pkg::lba_w-1:0]             sd_lba [4];
   logic [3:0]                              sd_rd;
   logic [3:0]                              sd_wr;
   logic [3:0]                              sd_ack;
   logic [8:0]                              sd_buff_addr;
   logic [7:0]                              sd_buff_din [4];
   logic [nvram_pkg::ram_addr_w-1:0]        ram_addr;
   logic                                    ram_we;
   logic [7:0]                              ram_dout;
   logic                                    busy;

   logic [7:0] ram_mem [mem_bytes];
   logic [7:0] img_mem [mem_bytes];   // Card images, one region per slot
   logic [7:0] exp_ram [mem_bytes];
   logic [7:0] exp_img [mem_bytes];
   logic [7:0] host_rd_data;
   int         blocks_seen [4];
   int         img_bytes [4];
   logic [3:0] writable_m;
   int         error_count;
   int         failed_tests;
   int         tests_run;
   logic       timed_out;

   nvram_backup nvram_backup_i (.*);

   always #20 clk = ~clk;

   assign ram_dout = ram_mem[ram_addr[13:0]];

   always @(negedge clk)
      if (ram_we)
         ram_mem[ram_addr[13:0]] = host_rd_data;   // Load data from the host

   task automatic check_value(input string name, input longint unsigned got,
                              input longint unsigned exp);
      assert (got == exp) else begin
         $display("CHECK FAILED at %0d ns: %s = 0x%0h, expected 0x%0h",
                  $time, name, got, exp);
         error_count++;
      end
   endtask

   task automatic wait_busy(input logic level, input int limit);
      int n;
      n = 0;
      while (busy !== level && n < limit) begin
         @(posedge clk);
         #2;
         n++;
      end
      if (busy !== level) begin
         $display("Timeout: busy did not go to %0b within %0d cycles", level, limit);
         error_count++;
         timed_out = 1'b1;
      end
   endtask

   // One 512-byte block, ack held high for its whole length
   task automatic serve_block();
      logic [3:0] strobes;
      logic       is_wr;
      int         s;
      int         base_idx;
      strobes = sd_rd | sd_wr;
      s = 0;
      for (int i = 0; i < 4; i++)
         if (strobes[i])
            s = i;
      check_value("active strobes", 64'($countones(strobes)), 64'd1);
      check_value("sd_rd & sd_wr", 64'(sd_rd & sd_wr), 64'd0);
      check_value($sformatf("sd_lba[%0d]", s), 64'(sd_lba[s]), 64'(blocks_seen[s]));
      is_wr = sd_wr[s];
      base_idx = s * region_bytes + int'(sd_lba[s]) * 512;
      for (int b = 0; b < 512; b++) begin
         sd_buff_addr = 9'(b);
         sd_ack[s] = 1'b1;
         host_rd_data = img_mem[(base_idx + b) % mem_bytes];
         @(negedge clk);
         if (is_wr)
            img_mem[(base_idx + b) % mem_bytes] = sd_buff_din[s];
         @(posedge clk);
         #2;
      end
      sd_ack[s] = 1'b0;
      blocks_seen[s] = blocks_seen[s] + 1;
   endtask

   always begin : sd_host
      @(posedge clk);
      #2;
      if (rst_n && (sd_rd | sd_wr) != '0)
         serve_block();
   end

   task automatic run_row(input int r);
      row_t       row;
      int         sz;
      logic       elig;
      int         errs_before;
      int         exp_blocks [4];
      logic [3:0] served;
      row = rows[r];
      errs_before = error_count;
      for (int i = 0; i < mem_bytes; i++)
         ram_mem[i] = 8'($urandom());
      for (int s = 0; s < 4; s++) begin
         sram_size[s] = 16'(row.kib[s]);
         blocks_seen[s] = 0;
         if (row.mount[s]) begin
            writable_m[s] = ~row.ro;
            img_bytes[s] = int'(row.img_kib) * 1024;
         end
      end
      img_mounted = row.mount;
      img_readonly = row.ro;
      img_size = 64'(row.img_kib) * 64'd1024;
      @(posedge clk);
      #2;
      img_mounted = '0;
      exp_ram = ram_mem;
      exp_img = img_mem;
      for (int s = 0; s < 4; s++) begin
         sz = int'(row.kib[s]) * 1024;
         elig = sz != 0 && writable_m[s] && (row.save || img_bytes[s] != 0);
         exp_blocks[s] = elig ? sz / 512 : 0;
         for (int i = 0; elig && i < sz; i++)
            if (row.save)
               exp_img[s * region_bytes + i] = ram_mem[s * region_bytes + i];
            else
               exp_ram[s * region_bytes + i] = img_mem[s * region_bytes + i];
         if (elig && row.save)
            img_bytes[s] = sz;
      end
      if (row.save)
         save_req = 1'b1;
      else
         load_req = 1'b1;
      wait_busy(1'b1, 8);
      if (timed_out)
         return;
      if (!row.hold)
         save_req = 1'b0;
      load_req = 1'b0;
      wait_busy(1'b0, 20000);
      if (timed_out)
         return;
      // A held request must not start a second round
      for (int n = 0; row.hold && n < 8; n++) begin
         @(posedge clk);
         #2;
         check_value("busy after round", 64'(busy), 64'd0);
      end
      save_req = 1'b0;
      for (int s = 0; s < 4; s++) begin
         served[s] = blocks_seen[s] != 0;
         check_value($sformatf("blocks on slot %0d", s), 64'(blocks_seen[s]),
                     64'(exp_blocks[s]));
      end
      check_value("served slots", 64'(served), 64'(row.served));
      check_value("sd_rd | sd_wr", 64'(sd_rd | sd_wr), 64'd0);
      for (int i = 0; i < mem_bytes; i++)
         if (ram_mem[i] !== exp_ram[i]) begin
            check_value($sformatf("ram[0x%0h]", i), 64'(ram_mem[i]), 64'(exp_ram[i]));
            break;
         end
      for (int i = 0; i < mem_bytes; i++)
         if (img_mem[i] !== exp_img[i]) begin
            check_value($sformatf("image[0x%0h]", i), 64'(img_mem[i]), 64'(exp_img[i]));
            break;
         end
      if (error_count != errs_before)
         failed_tests++;
      $display("Test %0d %s, slots %04b: %s", r, row.save ? "save" : "load", row.served,
               error_count == errs_before ? "ok" : "FAILED");
   endtask

   initial begin
      clk = 1'b0;
      rst_n = 1'b0;
      load_req = 1'b0;
      save_req = 1'b0;
      img_mounted = '0;
      img_readonly = 1'b0;
      img_size = '0;
      sd_ack = '0;
      sd_buff_addr = '0;
      host_rd_data = '0;
      writable_m = '0;
      error_count = 0;
      failed_tests = 0;
      tests_run = 0;
      timed_out = 1'b0;
      for (int s = 0; s < 4; s++) begin
         sram_base[s] = 27'(s * region_bytes);
         sram_size[s] = '0;
         img_bytes[s] = 0;
         blocks_seen[s] = 0;
      end
      void'($urandom(65));
      for (int i = 0; i < mem_bytes; i++)
         img_mem[i] = 8'($urandom());
      repeat (10) @(posedge clk);
      #2;
      rst_n = 1'b1;
      for (int r = 0; r < row_count && !timed_out; r++) begin
         run_row(r);
         tests_run++;
      end
      if (timed_out)
         failed_tests++;   // Row cut short by a timeout
      $display("Tests run: %0d, passed: %0d, failed: %0d, check errors: %0d",
               tests_run, tests_run - failed_tests, failed_tests, error_count);
      if (error_count == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- sources.f
nvram_pkg.sv
nvram_image_status.sv
nvram_request_scheduler.sv
nvram_block_mover.sv
nvram_backup.sv
nvram_backup_assertions.sv
tb_nvram_backup.sv

//--- Makefile
TOP = tb_nvram_backup

.PHONY: all build lint clean

all: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

build:
	verilator --binary --assert -j 0 --top-module $(TOP) -f sources.f

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f sources.f

clean:
	rm -rf obj_dir
